// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_alu
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "*** FAILED ***" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/alu_cmp.sv
// Relation flags are unsigned and signed views of the same operands and sit in bits 4:0 only
`timescale 1ns/10ps

module alu_cmp #(
	parameter int WID = alu_pkg::DEFAULT_WID
) (
	input  logic [WID-1:0] a,
	input  logic [WID-1:0] b,
	input  logic [WID-1:0] i,
	input  logic           cmp_imm,
	output logic [WID-1:0] cmpo
);

	logic [WID-1:0] rhs;

	// Immediate compares use the immediate as the second operand
	assign rhs = cmp_imm ? i : b;

	always_comb
	begin
		cmpo = '0;
		// Equal
		cmpo[0] = (a == rhs);
		// Signed less-than
		cmpo[1] = ($signed(a) < $signed(rhs));
		// Unsigned less-than
		cmpo[2] = (a < rhs);
		// Signed greater-than
		cmpo[3] = ($signed(a) > $signed(rhs));
		// Unsigned greater-than
		cmpo[4] = (a > rhs);
	end

endmodule

// File: hdl/alu_core.sv
// Fully combinational select; WID must be a multiple of 16 and multi-cycle results need held inputs
`timescale 1ns/10ps

module alu_core #(
	parameter int WID = alu_pkg::DEFAULT_WID
) (
	input  alu_pkg::alu_op_e op,
	input  alu_pkg::alu_fn_e fn,
	input  logic [2:0]       op2,
	input  logic [3:0]       cond,
	input  alu_pkg::cause_e  cause,
	input  logic             cptgt,
	input  logic             z,
	input  logic [WID-1:0]   a,
	input  logic [WID-1:0]   b,
	input  logic [WID-1:0]   c,
	input  logic [WID-1:0]   i,
	input  logic [WID-1:0]   t,
	input  logic [WID-1:0]   cpl,
	input  logic [WID-1:0]   canary,
	input  logic [WID-1:0]   cmpo,
	input  logic [2*WID-1:0] prod,
	input  logic [2*WID-1:0] produ,
	input  logic [WID-1:0]   div_q,
	input  logic [WID-1:0]   div_r,
	input  logic             div_dbz,
	output logic [WID-1:0]   mb,
	output logic             cmp_imm,
	output logic             div_sgn,
	output logic [WID-1:0]   o,
	output alu_pkg::cause_e  exc
);

	import alu_pkg::*;

	localparam int NB = WID / 8;
	localparam logic [WID-1:0] DEAD = {(WID/16){16'hDEAD}};

	logic eq, lt, ltu;
	logic [WID-1:0] r2_res, minmax_res, ndx, res;
	logic [WID-1:0] lo_ab, hi_ab;
	logic mm_sgn;
	logic [5:0] shamt;
	shift_fn_e sh_fn;
	logic chk_fail, chk_unimp;

	// Combines a two-operand result with c as selected by op2
	function automatic logic [WID-1:0] with_c(input logic [WID-1:0] x,
		input logic [WID-1:0] y, input logic [2:0] sel);
		case (sel)
		3'd0: with_c = x & y;
		3'd1: with_c = x | y;
		3'd2: with_c = x ^ y;
		default: with_c = '0;
		endcase
	endfunction

	function automatic logic less(input logic [WID-1:0] x, input logic [WID-1:0] y,
		input logic sgn);
		less = sgn ? ($signed(x) < $signed(y)) : (x < y);
	endfunction

	function automatic logic [WID-1:0] mn(input logic [WID-1:0] x, input logic [WID-1:0] y,
		input logic sgn);
		mn = less(x, y, sgn) ? x : y;
	endfunction

	function automatic logic [WID-1:0] mx(input logic [WID-1:0] x, input logic [WID-1:0] y,
		input logic sgn);
		mx = less(x, y, sgn) ? y : x;
	endfunction

	// Register forms use b, everything else the immediate
	assign mb = (op == OP_R2) ? b : i;
	assign cmp_imm = (op != OP_R2);
	assign div_sgn = (op == OP_DIVI) || (op == OP_R2 && (fn == FN_DIV || fn == FN_MOD));

	assign eq = cmpo[0];
	assign lt = cmpo[1];
	assign ltu = cmpo[2];
	assign shamt = c[5:0];
	assign sh_fn = shift_fn_e'(op2[1:0]);

	// op2 bit 2 picks unsigned; the median is max(min(a,b), min(max(a,b),c))
	always_comb
	begin
		mm_sgn = ~op2[2];
		lo_ab = mn(a, b, mm_sgn);
		hi_ab = mx(a, b, mm_sgn);
		case (op2[1:0])
		2'd0: minmax_res = mn(lo_ab, c, mm_sgn);
		2'd1: minmax_res = mx(hi_ab, c, mm_sgn);
		2'd2: minmax_res = mx(lo_ab, mn(hi_ab, c, mm_sgn), mm_sgn);
		default: minmax_res = DEAD;
		endcase
	end

	// Lowest matching byte wins, so the scan runs from the top down
	always_comb
	begin
		ndx = '1;
		for (int k = NB - 1; k >= 0; k--)
			if (a[k*8 +: 8] == b[k*8 +: 8])
				ndx = WID'(k);
	end

	// ==========================================================
	// Register-register functions
	// ==========================================================
	always_comb
	begin
		case (fn)
		FN_ADD: r2_res = with_c(a + b, c, op2);
		FN_SUB: r2_res = a - b - c;
		FN_AND: r2_res = with_c(a & b, c, op2);
		FN_OR: r2_res = with_c(a | b, c, op2);
		FN_EOR: r2_res = with_c(a ^ b, c, op2);
		FN_NAND: r2_res = with_c(~(a & b), c, op2);
		FN_NOR: r2_res = with_c(~(a | b), c, op2);
		FN_ENOR: r2_res = with_c(~(a ^ b), c, op2);
		FN_CMP, FN_CMPU: r2_res = cmpo;
		FN_MUL: r2_res = prod[WID-1:0];
		FN_MULU: r2_res = produ[WID-1:0];
		FN_MULW: r2_res = prod[2*WID-1:WID];
		FN_MULUW: r2_res = produ[2*WID-1:WID];
		FN_DIV, FN_DIVU: r2_res = div_q;
		FN_MOD, FN_MODU: r2_res = div_r;
		FN_CMOVZ: r2_res = (a == '0) ? b : c;
		FN_CMOVNZ: r2_res = (a != '0) ? b : c;
		FN_SEQ: r2_res = eq ? c : t;
		FN_SLT: r2_res = lt ? c : t;
		FN_SLTU: r2_res = ltu ? c : t;
		FN_ZSEQ: r2_res = eq ? c : '0;
		FN_ZSLT: r2_res = lt ? c : '0;
		FN_ZSLTU: r2_res = ltu ? c : '0;
		FN_MINMAX: r2_res = minmax_res;
		FN_BYTENDX: r2_res = ndx;
		default: r2_res = DEAD;
		endcase
	end

	// ==========================================================
	// Checks
	// ==========================================================
	// Bounds compares are unsigned
	always_comb
	begin
		chk_unimp = 1'b0;
		case (cond)
		4'd0: chk_fail = !(a >= b && a < c);
		4'd1: chk_fail = !(a >= b && a <= c);
		4'd2: chk_fail = !(a > b && a < c);
		4'd3: chk_fail = !(a > b && a <= c);
		4'd4: chk_fail = (a >= b && a < c);
		4'd5: chk_fail = (a >= b && a <= c);
		4'd6: chk_fail = (a > b && a < c);
		4'd7: chk_fail = (a > b && a <= c);
		4'd8: chk_fail = (a < cpl);
		4'd9: chk_fail = (a > cpl);
		4'd10: chk_fail = (a != canary);
		default:
		begin
			chk_fail = 1'b0;
			chk_unimp = 1'b1;
		end
		endcase
	end

	always_comb
	begin
		exc = FLT_NONE;
		case (op)
		OP_R2: res = r2_res;
		OP_CHK:
		begin
			res = '0;
			if (chk_unimp)
				exc = FLT_UNIMP;
			else if (chk_fail)
				exc = cause;
		end
		OP_ADDI: res = a + i;
		OP_SUBFI: res = i - a;
		OP_ANDI: res = a & i;
		OP_ORI: res = a | i;
		OP_EORI: res = a ^ i;
		OP_CMPI, OP_CMPUI: res = cmpo;
		OP_MULI: res = prod[WID-1:0];
		OP_MULUI: res = produ[WID-1:0];
		OP_DIVI:
		begin
			res = div_q;
			if (div_dbz)
				exc = FLT_DBZ;
		end
		OP_DIVUI: res = div_q;
		OP_SHIFT:
			if (op2[2])
				res = DEAD;
			else
				case (sh_fn)
				SH_ASL: res = a << shamt;
				SH_LSR: res = a >> shamt;
				SH_ASR: res = $signed(a) >>> shamt;
				default: res = DEAD;
				endcase
		OP_SEQI: res = eq ? WID'(1) : t;
		OP_SLTI: res = lt ? WID'(1) : t;
		OP_SLTUI: res = ltu ? WID'(1) : t;
		OP_ZSEQI: res = WID'(eq);
		OP_ZSLTI: res = WID'(lt);
		OP_ZSLTUI: res = WID'(ltu);
		OP_MOV: res = a;
		OP_NOP: res = '0;
		default: res = DEAD;
		endcase
	end

	// A predicated-off operation keeps the old target or clears it
	assign o = cptgt ? (z ? '0 : t) : res;

endmodule

// File: hdl/alu_divider.sv
// Takes WID+1 clocks per divide and one for a zero divisor; a new ld restarts the unit
`timescale 1ns/10ps

module alu_divider #(
	parameter int WID = alu_pkg::DEFAULT_WID
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           ld,
	input  logic           div_sgn,
	input  logic [WID-1:0] a,
	input  logic [WID-1:0] mb,
	output logic [WID-1:0] div_q,
	output logic [WID-1:0] div_r,
	output logic           div_dbz,
	output logic           div_done
);

	localparam int CW = $clog2(WID) + 1;

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_DONE
	} div_state_e;

	div_state_e state;
	logic [CW-1:0] cnt;
	logic [WID-1:0] q_reg;
	logic [WID-1:0] d_reg;
	logic [WID:0] r_reg;
	logic q_neg, r_neg;
	logic [WID-1:0] a_mag, b_mag;
	logic [WID:0] r_shift, r_diff;

	// Magnitudes for a signed divide, and one restoring step
	always_comb
	begin
		a_mag = (div_sgn && a[WID-1]) ? -a : a;
		b_mag = (div_sgn && mb[WID-1]) ? -mb : mb;
		r_shift = {r_reg[WID-1:0], q_reg[WID-1]};
		r_diff = r_shift - {1'b0, d_reg};
	end

	// ==========================================================
	// Control
	// ==========================================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= DIV_IDLE;
			div_dbz <= 1'b0;
		end
		else if (ld)
		begin
			state <= (mb == '0) ? DIV_DONE : DIV_RUN;
			div_dbz <= (mb == '0);
		end
		else if (state == DIV_RUN && cnt == CW'(1))
			state <= DIV_DONE;
	end

	// ==========================================================
	// Datapath
	// ==========================================================
	always_ff @(posedge clk)
	begin
		if (ld)
		begin
			cnt <= CW'(WID);
			if (mb == '0)
			begin
				// Divide by zero gives all ones and leaves the dividend as remainder
				q_reg <= '1;
				r_reg <= {1'b0, a};
				q_neg <= 1'b0;
				r_neg <= 1'b0;
			end
			else
			begin
				q_reg <= a_mag;
				r_reg <= '0;
				d_reg <= b_mag;
				q_neg <= div_sgn & (a[WID-1] ^ mb[WID-1]);
				r_neg <= div_sgn & a[WID-1];
			end
		end
		else if (state == DIV_RUN)
		begin
			cnt <= cnt - CW'(1);
			// A clear top bit means the divisor fitted
			if (!r_diff[WID])
			begin
				r_reg <= r_diff;
				q_reg <= {q_reg[WID-2:0], 1'b1};
			end
			else
			begin
				r_reg <= r_shift;
				q_reg <= {q_reg[WID-2:0], 1'b0};
			end
		end
	end

	// Remainder takes the sign of the dividend
	assign div_q = q_neg ? -q_reg : q_reg;
	assign div_r = r_neg ? -r_reg[WID-1:0] : r_reg[WID-1:0];
	assign div_done = (state == DIV_DONE);

endmodule

// File: hdl/alu_multiplier.sv
// Operands must stay stable from ld until mul_done; products lag the operands by three clocks
`timescale 1ns/10ps

module alu_multiplier #(
	parameter int WID = alu_pkg::DEFAULT_WID
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             ld,
	input  logic [WID-1:0]   a,
	input  logic [WID-1:0]   mb,
	output logic [2*WID-1:0] prod,
	output logic [2*WID-1:0] produ,
	output logic             mul_done
);

	logic [2*WID-1:0] prod_s1, prod_s2;
	logic [2*WID-1:0] produ_s1, produ_s2;
	logic [3:0] mul_cnt;
	logic mul_armed;

	// Signed and unsigned products side by side, three register stages deep
	always_ff @(posedge clk)
	begin
		prod_s1 <= $signed({{WID{a[WID-1]}}, a}) * $signed({{WID{mb[WID-1]}}, mb});
		prod_s2 <= prod_s1;
		prod <= prod_s2;
		produ_s1 <= {{WID{1'b0}}, a} * {{WID{1'b0}}, mb};
		produ_s2 <= produ_s1;
		produ <= produ_s2;
	end

	// The counter fills with ones after ld and its top bit becomes done
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			mul_cnt <= 4'hF;
			mul_armed <= 1'b0;
			mul_done <= 1'b0;
		end
		else if (ld)
		begin
			mul_cnt <= 4'h0;
			mul_armed <= 1'b1;
			mul_done <= 1'b0;
		end
		else
		begin
			mul_cnt <= {mul_cnt[2:0], 1'b1};
			mul_done <= mul_cnt[3] & mul_armed;
		end
	end

endmodule

// File: hdl/alu_pkg.sv
// Encodings shared by the integer lane; opcode values must match the decoder that feeds it
package alu_pkg;

	// Datapath width used when the top level is not given one
	localparam int DEFAULT_WID = 64;

	// ==========================================================
	// Major opcodes
	// ==========================================================
	typedef enum logic [6:0] {
		OP_R2     = 7'h02,
		OP_CHK    = 7'h03,
		OP_ADDI   = 7'h04,
		OP_SUBFI  = 7'h05,
		OP_CMPI   = 7'h06,
		OP_CMPUI  = 7'h07,
		OP_ANDI   = 7'h08,
		OP_ORI    = 7'h09,
		OP_EORI   = 7'h0A,
		OP_MULI   = 7'h0C,
		OP_MULUI  = 7'h0D,
		OP_DIVI   = 7'h0E,
		OP_DIVUI  = 7'h0F,
		OP_SHIFT  = 7'h10,
		OP_SEQI   = 7'h18,
		OP_SLTI   = 7'h19,
		OP_SLTUI  = 7'h1A,
		OP_ZSEQI  = 7'h1C,
		OP_ZSLTI  = 7'h1D,
		OP_ZSLTUI = 7'h1E,
		OP_MOV    = 7'h20,
		OP_NOP    = 7'h7F
	} alu_op_e;

	// ==========================================================
	// Register-register functions
	// ==========================================================
	typedef enum logic [6:0] {
		FN_ADD = 7'h04, FN_SUB = 7'h05, FN_CMP = 7'h06, FN_CMPU = 7'h07,
		FN_AND = 7'h08, FN_OR = 7'h09, FN_EOR = 7'h0A,
		FN_NAND = 7'h0C, FN_NOR = 7'h0D, FN_ENOR = 7'h0E,
		FN_MUL = 7'h10, FN_MULU = 7'h11, FN_MULW = 7'h12, FN_MULUW = 7'h13,
		FN_DIV = 7'h14, FN_DIVU = 7'h15, FN_MOD = 7'h16, FN_MODU = 7'h17,
		FN_CMOVZ = 7'h18, FN_CMOVNZ = 7'h19,
		FN_SEQ = 7'h20, FN_SLT = 7'h21, FN_SLTU = 7'h22,
		FN_ZSEQ = 7'h28, FN_ZSLT = 7'h29, FN_ZSLTU = 7'h2A,
		FN_MINMAX = 7'h30, FN_BYTENDX = 7'h31
	} alu_fn_e;

	// Shift kind, carried in the low two bits of op2
	typedef enum logic [1:0] {
		SH_ASL = 2'd0,
		SH_LSR = 2'd1,
		SH_ASR = 2'd2
	} shift_fn_e;

	// Exception causes reported on exc
	typedef enum logic [7:0] {
		FLT_NONE   = 8'h00,
		FLT_DBZ    = 8'h10,
		FLT_UNIMP  = 8'h11,
		FLT_BOUNDS = 8'h12,
		FLT_PRIV   = 8'h13,
		FLT_CANARY = 8'h14
	} cause_e;

endpackage

// File: hdl/alu_top.sv
// One integer lane; the caller holds all operation inputs from ld until the matching done
`timescale 1ns/10ps

module alu_top #(
	parameter int WID = alu_pkg::DEFAULT_WID
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             ld,
	input  alu_pkg::alu_op_e op,
	input  alu_pkg::alu_fn_e fn,
	input  logic [2:0]       op2,
	input  logic [3:0]       cond,
	input  alu_pkg::cause_e  cause,
	input  logic             cptgt,
	input  logic             z,
	input  logic [WID-1:0]   a,
	input  logic [WID-1:0]   b,
	input  logic [WID-1:0]   c,
	input  logic [WID-1:0]   i,
	input  logic [WID-1:0]   t,
	input  logic [WID-1:0]   cpl,
	input  logic [WID-1:0]   canary,
	output logic [WID-1:0]   o,
	output alu_pkg::cause_e  exc,
	output logic             mul_done,
	output logic             div_done,
	output logic             div_dbz
);

	logic [WID-1:0] cmpo, mb, div_q, div_r;
	logic [2*WID-1:0] prod, produ;
	logic cmp_imm, div_sgn;

	alu_cmp #(.WID(WID)) u_cmp (.a(a), .b(b), .i(i), .cmp_imm(cmp_imm), .cmpo(cmpo));

	alu_multiplier #(.WID(WID)) u_mul (.clk(clk), .rst(rst), .ld(ld), .a(a), .mb(mb),
		.prod(prod), .produ(produ), .mul_done(mul_done));

	alu_divider #(.WID(WID)) u_div (.clk(clk), .rst(rst), .ld(ld), .div_sgn(div_sgn),
		.a(a), .mb(mb), .div_q(div_q), .div_r(div_r), .div_dbz(div_dbz),
		.div_done(div_done));

	alu_core #(.WID(WID)) u_core (.op(op), .fn(fn), .op2(op2), .cond(cond), .cause(cause),
		.cptgt(cptgt), .z(z), .a(a), .b(b), .c(c), .i(i), .t(t), .cpl(cpl),
		.canary(canary), .cmpo(cmpo), .prod(prod), .produ(produ), .div_q(div_q),
		.div_r(div_r), .div_dbz(div_dbz), .mb(mb), .cmp_imm(cmp_imm),
		.div_sgn(div_sgn), .o(o), .exc(exc));

endmodule

// File: sources.f
hdl/alu_pkg.sv
hdl/alu_cmp.sv
hdl/alu_multiplier.sv
hdl/alu_divider.sv
hdl/alu_core.sv
hdl/alu_top.sv
tb/alu_clkgen.sv
tb/tb_alu.sv

// File: tb/alu_clkgen.sv
// Free-running testbench clock; reset is released 1 ns after the last reset edge
`timescale 1ns/10ps

module alu_clkgen #(
	parameter real PERIOD = 4.0,
	parameter int RST_CYCLES = 3
) (
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

	initial
	begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

// File: tb/tb_alu.sv
// WID 64 only; inputs change 1 ns after a rising edge and outputs are read at falling edges
`timescale 1ns/10ps

module tb_alu;

	import alu_pkg::*;

	localparam int WID = 64;
	localparam int N_ITER = 16;
	localparam int N_OPS = 1400;
	localparam real TIMEOUT_NS = N_OPS * (WID + 10) * 4.0 + 2000.0;
	localparam logic [WID-1:0] DEAD = {(WID/16){16'hDEAD}};
	localparam logic [WID-1:0] MIN_S = {1'b1, {(WID-1){1'b0}}};

	logic clk, rst, ld, cptgt, z;
	alu_op_e op;
	alu_fn_e fn;
	logic [2:0] op2;
	logic [3:0] cond;
	cause_e cause;
	logic [WID-1:0] a, b, c, i, t, cpl, canary, o;
	cause_e exc;
	logic mul_done, div_done, div_dbz;

	integer seed = 97690;
	int errors = 0;
	int checks = 0;
	string tname;
	logic [WID-1:0] exp_o;
	logic [7:0] exp_exc;
	event check_ev;

	alu_clkgen #(.PERIOD(4.0), .RST_CYCLES(3)) u_clk (.clk(clk), .rst(rst));

	alu_top #(.WID(WID)) dut0 (.clk(clk), .rst(rst), .ld(ld), .op(op), .fn(fn), .op2(op2),
		.cond(cond), .cause(cause), .cptgt(cptgt), .z(z), .a(a), .b(b), .c(c), .i(i),
		.t(t), .cpl(cpl), .canary(canary), .o(o), .exc(exc), .mul_done(mul_done),
		.div_done(div_done), .div_dbz(div_dbz));

	// ==========================================================
	// Reference model
	// ==========================================================
	function automatic logic is_less(input logic [WID-1:0] x, input logic [WID-1:0] y,
		input logic sgn);
		is_less = sgn ? ($signed(x) < $signed(y)) : (x < y);
	endfunction

	function automatic logic [WID-1:0] mix_c(input logic [WID-1:0] x,
		input logic [WID-1:0] y, input logic [2:0] s);
		mix_c = (s == 3'd0) ? (x & y) : (s == 3'd1) ? (x | y) : (s == 3'd2) ? (x ^ y) : '0;
	endfunction

	function automatic logic [WID+7:0] alu_model(input alu_op_e f_op, input alu_fn_e f_fn,
		input logic [2:0] s, input logic [3:0] cd, input cause_e cs, input logic cp,
		input logic zz, input logic [WID-1:0] x, input logic [WID-1:0] y,
		input logic [WID-1:0] w, input logic [WID-1:0] im, input logic [WID-1:0] tg,
		input logic [WID-1:0] pl, input logic [WID-1:0] cn);
		logic [WID-1:0] r, m, dq, dr, v0, v1, v2, tmp, flags;
		logic [2*WID-1:0] ps, pu;
		logic eq, lt, ltu, sg, inr, fail, found;
		logic [7:0] e;
		m = (f_op == OP_R2) ? y : im;
		eq = (x == m);
		lt = $signed(x) < $signed(m);
		ltu = x < m;
		flags = '0;
		flags[4:0] = {x > m, $signed(x) > $signed(m), ltu, lt, eq};
		ps = {{WID{x[WID-1]}}, x} * {{WID{m[WID-1]}}, m};
		pu = {{WID{1'b0}}, x} * {{WID{1'b0}}, m};
		sg = (f_op == OP_DIVI) || (f_op == OP_R2 && (f_fn == FN_DIV || f_fn == FN_MOD));
		if (m == '0)
		begin
			dq = '1;
			dr = x;
		end
		else if (sg)
		begin
			dq = $signed(x) / $signed(m);
			dr = $signed(x) % $signed(m);
		end
		else
		begin
			dq = x / m;
			dr = x % m;
		end
		// Sort the three operands for min, mid and max
		v0 = x;
		v1 = y;
		v2 = w;
		if (is_less(v1, v0, ~s[2]))
		begin
			tmp = v0;
			v0 = v1;
			v1 = tmp;
		end
		if (is_less(v2, v1, ~s[2]))
		begin
			tmp = v1;
			v1 = v2;
			v2 = tmp;
		end
		if (is_less(v1, v0, ~s[2]))
		begin
			tmp = v0;
			v0 = v1;
			v1 = tmp;
		end
		e = FLT_NONE;
		r = DEAD;
		case (f_op)
		OP_R2:
			case (f_fn)
			FN_ADD: r = mix_c(x + y, w, s);
			FN_SUB: r = x - y - w;
			FN_AND: r = mix_c(x & y, w, s);
			FN_OR: r = mix_c(x | y, w, s);
			FN_EOR: r = mix_c(x ^ y, w, s);
			FN_NAND: r = mix_c(~(x & y), w, s);
			FN_NOR: r = mix_c(~(x | y), w, s);
			FN_ENOR: r = mix_c(~(x ^ y), w, s);
			FN_CMP, FN_CMPU: r = flags;
			FN_MUL: r = ps[WID-1:0];
			FN_MULU: r = pu[WID-1:0];
			FN_MULW: r = ps[2*WID-1:WID];
			FN_MULUW: r = pu[2*WID-1:WID];
			FN_DIV, FN_DIVU: r = dq;
			FN_MOD, FN_MODU: r = dr;
			FN_CMOVZ: r = (x == '0) ? y : w;
			FN_CMOVNZ: r = (x != '0) ? y : w;
			FN_SEQ: r = eq ? w : tg;
			FN_SLT: r = lt ? w : tg;
			FN_SLTU: r = ltu ? w : tg;
			FN_ZSEQ: r = eq ? w : '0;
			FN_ZSLT: r = lt ? w : '0;
			FN_ZSLTU: r = ltu ? w : '0;
			FN_MINMAX:
				r = (s[1:0] == 2'd0) ? v0 : (s[1:0] == 2'd1) ? v2 : (s[1:0] == 2'd2) ? v1 : DEAD;
			FN_BYTENDX:
			begin
				found = 1'b0;
				r = '1;
				for (int k = 0; k < WID / 8; k++)
					if (!found && x[k*8 +: 8] == y[k*8 +: 8])
					begin
						found = 1'b1;
						r = WID'(k);
					end
			end
			default: r = DEAD;
			endcase
		OP_CHK:
		begin
			r = '0;
			// Bit 1 of a bounds condition makes the low bound exclusive, bit 0 the high one inclusive
			inr = (cd[1] ? (x > y) : (x >= y)) && (cd[0] ? (x <= w) : (x < w));
			fail = cd[2] ? inr : !inr;
			if (cd == 4'd8)
				fail = x < pl;
			else if (cd == 4'd9)
				fail = x > pl;
			else if (cd == 4'd10)
				fail = x != cn;
			if (cd > 4'd10)
				e = FLT_UNIMP;
			else if (fail)
				e = cs;
		end
		OP_ADDI: r = x + im;
		OP_SUBFI: r = im - x;
		OP_ANDI: r = x & im;
		OP_ORI: r = x | im;
		OP_EORI: r = x ^ im;
		OP_CMPI, OP_CMPUI: r = flags;
		OP_MULI: r = ps[WID-1:0];
		OP_MULUI: r = pu[WID-1:0];
		OP_DIVI:
		begin
			r = dq;
			if (m == '0)
				e = FLT_DBZ;
		end
		OP_DIVUI: r = dq;
		OP_SHIFT:
			if (s == 3'd0)
				r = x << w[5:0];
			else if (s == 3'd1)
				r = x >> w[5:0];
			else if (s == 3'd2)
				r = $signed(x) >>> w[5:0];
		OP_SEQI: r = eq ? WID'(1) : tg;
		OP_SLTI: r = lt ? WID'(1) : tg;
		OP_SLTUI: r = ltu ? WID'(1) : tg;
		OP_ZSEQI: r = WID'(eq);
		OP_ZSLTI: r = WID'(lt);
		OP_ZSLTUI: r = WID'(ltu);
		OP_MOV: r = x;
		OP_NOP: r = '0;
		default: r = DEAD;
		endcase
		if (cp)
			r = zz ? '0 : tg;
		alu_model = {e, r};
	endfunction

	// Compares the DUT with the expected values posted by the stimulus
	always @(check_ev)
	begin
		checks = checks + 1;
		if (o !== exp_o)
		begin
			errors = errors + 1;
			$display("[FAIL] %s o expected %h actual %h", tname, exp_o, o);
		end
		if (exc !== exp_exc)
		begin
			errors = errors + 1;
			$display("[FAIL] %s exc expected %h actual %h", tname, exp_exc, exc);
		end
	end

	// ==========================================================
	// Stimulus helpers
	// ==========================================================
	function automatic logic [WID-1:0] rval();
		int sel;
		sel = $random(seed) & 7;
		case (sel)
		0: rval = '0;
		1: rval = WID'(1);
		2: rval = '1;
		3: rval = MIN_S;
		4: rval = ~MIN_S;
		default: rval = {$random(seed), $random(seed)};
		endcase
	endfunction

	task automatic slot();
		@(posedge clk);
		#1;
	endtask

	task automatic new_operands();
		a = rval();
		b = (($random(seed) & 3) == 0) ? a : rval();
		c = rval();
		i = (($random(seed) & 3) == 0) ? a : rval();
		t = rval();
	endtask

	task automatic post_check(input string name);
		logic [WID+7:0] res;
		res = alu_model(op, fn, op2, cond, cause, cptgt, z, a, b, c, i, t, cpl, canary);
		tname = name;
		exp_o = res[WID-1:0];
		exp_exc = res[WID+7:WID];
		-> check_ev;
	endtask

	task automatic run_comb(input string name);
		@(posedge clk);
		@(negedge clk);
		post_check(name);
	endtask

	task automatic do_comb(input alu_op_e o_, input alu_fn_e f_, input logic [2:0] s_,
		input string name);
		slot();
		op = o_;
		fn = f_;
		op2 = s_;
		cptgt = 1'b0;
		new_operands();
		run_comb(name);
	endtask

	// Launches a multiply or divide with ld and waits for its done level
	task automatic do_multi(input alu_op_e o_, input alu_fn_e f_, input bit is_div,
		input bit zero_div, input string name);
		int cnt;
		logic [WID-1:0] mbv;
		slot();
		op = o_;
		fn = f_;
		cptgt = 1'b0;
		new_operands();
		if (a == MIN_S)
			a = a + WID'(1);
		if (zero_div)
		begin
			b = '0;
			i = '0;
		end
		mbv = (o_ == OP_R2) ? b : i;
		ld = 1'b1;
		slot();
		ld = 1'b0;
		@(negedge clk);
		if (!is_div && mul_done !== 1'b0)
		begin
			errors = errors + 1;
			$display("%s: mul_done was already high one cycle after ld", name);
		end
		cnt = 0;
		while (!(is_div ? div_done : mul_done) && cnt < WID + 20)
		begin
			@(negedge clk);
			cnt = cnt + 1;
		end
		if (cnt >= WID + 20)
		begin
			errors = errors + 1;
			$display("%s: done never came within %0d cycles", name, WID + 20);
		end
		else
		begin
			post_check(name);
			if (is_div && div_dbz !== (mbv == '0))
			begin
				errors = errors + 1;
				$display("[FAIL] %s div_dbz expected %b actual %b", name, mbv == '0, div_dbz);
			end
		end
	endtask

	task automatic do_chk(input logic [3:0] cd, input cause_e cs, input logic [WID-1:0] x,
		input logic [WID-1:0] lo, input logic [WID-1:0] hi, input string name);
		slot();
		op = OP_CHK;
		cond = cd;
		cause = cs;
		cptgt = 1'b0;
		a = x;
		b = lo;
		c = hi;
		cpl = WID'(5);
		canary = WID'(150);
		run_comb(name);
	endtask

	task automatic do_bytendx(input logic [WID-1:0] x, input logic [WID-1:0] y,
		input string name);
		slot();
		op = OP_R2;
		fn = FN_BYTENDX;
		cptgt = 1'b0;
		a = x;
		b = y;
		run_comb(name);
	endtask

	// ==========================================================
	// Test sequence
	// ==========================================================
	initial
	begin
		alu_fn_e logic_fns[7];
		alu_fn_e cmp_fns[10];
		alu_op_e imm_ops[15];
		logic [2:0] mm_sel[6];
		logic_fns = '{FN_ADD, FN_AND, FN_OR, FN_EOR, FN_NAND, FN_NOR, FN_ENOR};
		cmp_fns = '{FN_CMP, FN_CMPU, FN_SEQ, FN_SLT, FN_SLTU, FN_ZSEQ, FN_ZSLT, FN_ZSLTU,
			FN_CMOVZ, FN_CMOVNZ};
		imm_ops = '{OP_ADDI, OP_SUBFI, OP_ANDI, OP_ORI, OP_EORI, OP_MOV, OP_NOP, OP_CMPI,
			OP_CMPUI, OP_SEQI, OP_SLTI, OP_SLTUI, OP_ZSEQI, OP_ZSLTI, OP_ZSLTUI};
		mm_sel = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd6};
		ld = 1'b0;
		op = OP_NOP;
		fn = FN_ADD;
		op2 = '0;
		cond = '0;
		cause = FLT_NONE;
		cptgt = 1'b0;
		z = 1'b0;
		a = '0;
		b = '0;
		c = '0;
		i = '0;
		t = '0;
		cpl = '0;
		canary = '0;
		while (rst !== 1'b0)
			@(posedge clk);
		@(negedge clk);
		if (mul_done !== 1'b0 || div_done !== 1'b0 || div_dbz !== 1'b0)
		begin
			errors = errors + 1;
			$display("A done or div_dbz output was high after reset without any ld");
		end
		for (int it = 0; it < N_ITER; it++)
		begin
			foreach (logic_fns[k])
				for (int s = 0; s < 4; s++)
					do_comb(OP_R2, logic_fns[k], 3'(s), "logic");
			do_comb(OP_R2, FN_SUB, 3'd0, "sub");
			foreach (imm_ops[k])
				do_comb(imm_ops[k], FN_ADD, 3'd0, "immediate");
			foreach (cmp_fns[k])
				do_comb(OP_R2, cmp_fns[k], 3'd0, "compare");
			foreach (mm_sel[k])
				do_comb(OP_R2, FN_MINMAX, mm_sel[k], "minmax");
			for (int s = 0; s < 3; s++)
				do_comb(OP_SHIFT, FN_ADD, 3'(s), "shift");
			do_multi(OP_R2, FN_MUL, 1'b0, 1'b0, "mul");
			do_multi(OP_R2, FN_MULU, 1'b0, 1'b0, "mulu");
			do_multi(OP_R2, FN_MULW, 1'b0, 1'b0, "mulw");
			do_multi(OP_R2, FN_MULUW, 1'b0, 1'b0, "muluw");
			do_multi(OP_MULI, FN_ADD, 1'b0, 1'b0, "muli");
			do_multi(OP_MULUI, FN_ADD, 1'b0, 1'b0, "mului");
			do_multi(OP_R2, FN_DIV, 1'b1, it % 5 == 0, "div");
			do_multi(OP_R2, FN_DIVU, 1'b1, it % 5 == 1, "divu");
			do_multi(OP_R2, FN_MOD, 1'b1, it % 5 == 2, "mod");
			do_multi(OP_R2, FN_MODU, 1'b1, it % 5 == 3, "modu");
			do_multi(OP_DIVI, FN_ADD, 1'b1, it % 4 == 0, "divi");
			do_multi(OP_DIVUI, FN_ADD, 1'b1, it % 4 == 1, "divui");
			// Predicated-off operation returns t, or zero with z high
			slot();
			op = OP_ADDI;
			new_operands();
			cptgt = 1'b1;
			z = it[0];
			run_comb("copy target");
		end
		for (int cd = 0; cd < 8; cd++)
			for (int x = 50; x <= 250; x += 50)
				do_chk(4'(cd), FLT_BOUNDS, WID'(x), WID'(100), WID'(200), "bounds");
		for (int x = 3; x <= 9; x += 2)
		begin
			do_chk(4'd8, FLT_PRIV, WID'(x), '0, '0, "priv low");
			do_chk(4'd9, FLT_PRIV, WID'(x), '0, '0, "priv high");
		end
		do_chk(4'd10, FLT_CANARY, WID'(150), '0, '0, "canary match");
		do_chk(4'd10, FLT_CANARY, WID'(151), '0, '0, "canary broken");
		for (int cd = 11; cd < 16; cd++)
			do_chk(4'(cd), FLT_BOUNDS, WID'(150), WID'(100), WID'(200), "unknown cond");
		do_bytendx(64'h0011223344556677, 64'hFFEEDDCCBBAA9988, "bytendx none");
		do_bytendx(64'h0011223344556677, 64'hFFEEDD33BBAA9988, "bytendx one");
		do_bytendx(64'h0011223344556677, 64'h0011DD33BBAA9977, "bytendx several");
		do_bytendx(64'h0011223344556677, 64'h0011223344556677, "bytendx all");
		@(negedge clk);
		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// Ends a run that stalls well beyond the longest expected sequence
	initial
	begin
		#(TIMEOUT_NS);
		$display("Simulation timed out after %0.0f ns", TIMEOUT_NS);
		$display("*** FAILED ***");
		$finish;
	end

endmodule
